//--- common/backend_pkg.sv
package backend_pkg;

    localparam int XLEN      = 32;
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    // Major opcodes, bits 31..22.
    localparam logic [9:0] OP_LD_W = 10'b0010100010;
    localparam logic [9:0] OP_ST_W = 10'b0010100110;

    // CSR access group, bits 31..24.
    localparam logic [7:0] OP_CSR = 8'b00000100;

    localparam logic [16:0] INST_SYSCALL_HI = 17'b00000000001010110;
    localparam logic [31:0] INST_ERTN       = 32'h0648_3800;

    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    localparam logic [5:0] ECODE_SYS = 6'h0b;

    // ld.w / st.w format.
    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } reg2i12_t;

    // csrrd / csrwr / csrxchg format; rj selects the variant.
    typedef struct packed {
        logic [7:0]  op;
        logic [13:0] csr_num;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } csr_inst_t;

    typedef union packed {
        reg2i12_t  r2i12;
        csr_inst_t csr;
    } la_inst_t;

endpackage

//--- rtl/reg_file.sv
module reg_file (
    input  logic                         clk,
    input  logic                         we,
    input  logic [4:0]                   waddr,
    input  logic [backend_pkg::XLEN-1:0] wdata,
    input  logic [4:0]                   raddr,
    output logic [backend_pkg::XLEN-1:0] rdata
);

    logic [backend_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

endmodule

//--- mem/data_ram.sv
module data_ram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [backend_pkg::RAM_AW-1:0] addr,
    input  logic [backend_pkg::XLEN-1:0]   wdata,
    output logic [backend_pkg::XLEN-1:0]   rdata
);

    logic [backend_pkg::XLEN-1:0] mem [backend_pkg::RAM_WORDS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr]; // Old data on a write.
        end
    end

endmodule

//--- mem/mem_stage.sv
module mem_stage (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             ex_valid,
    input  logic [backend_pkg::XLEN-1:0]     ex_pc,
    input  logic [31:0]                      ex_inst,
    input  logic [backend_pkg::XLEN-1:0]     ex_result,
    input  logic [backend_pkg::XLEN-1:0]     ex_rkd,
    input  logic [backend_pkg::XLEN-1:0]     ex_rj_value,
    input  logic                             flush,
    input  logic [backend_pkg::XLEN-1:0]     ram_rdata,
    output logic                             mem_allowin,
    output logic                             ram_en,
    output logic                             ram_we,
    output logic [backend_pkg::RAM_AW-1:0]   ram_addr,
    output logic [backend_pkg::XLEN-1:0]     ram_wdata,
    output logic                             mem_wb_valid,
    output logic [backend_pkg::XLEN-1:0]     mem_wb_pc,
    output logic [31:0]                      mem_wb_inst,
    output logic [backend_pkg::XLEN-1:0]     mem_wb_result,
    output logic [4:0]                       mem_wb_dest,
    output logic                             mem_wb_gr_we,
    output logic                             mem_wb_csr_re,
    output logic                             mem_wb_csr_we,
    output logic [13:0]                      mem_wb_csr_num,
    output logic [backend_pkg::XLEN-1:0]     mem_wb_csr_wmask,
    output logic [backend_pkg::XLEN-1:0]     mem_wb_csr_wvalue,
    output logic                             mem_wb_syscall,
    output logic                             mem_wb_ertn
);

    logic                         mem_valid;
    logic                         rd_done;
    logic [backend_pkg::XLEN-1:0] mem_pc;
    logic [31:0]                  mem_inst;
    logic [backend_pkg::XLEN-1:0] mem_result;
    logic [backend_pkg::XLEN-1:0] mem_rkd;
    logic [backend_pkg::XLEN-1:0] mem_rj_value;
    backend_pkg::la_inst_t        inst;
    logic                         is_load;
    logic                         is_store;
    logic                         is_csr;
    logic                         ready_go;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            mem_valid <= 1'b0; // An offer taken during flush is dropped here.
        end else if (mem_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && mem_allowin) begin
            mem_pc       <= ex_pc;
            mem_inst     <= ex_inst;
            mem_result   <= ex_result;
            mem_rkd      <= ex_rkd;
            mem_rj_value <= ex_rj_value;
        end
    end

    // Marks the data cycle of a load.
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= mem_valid && is_load && !rd_done;
        end
    end

    assign inst     = backend_pkg::la_inst_t'(mem_inst);
    assign is_load  = inst.r2i12.op == backend_pkg::OP_LD_W;
    assign is_store = inst.r2i12.op == backend_pkg::OP_ST_W;
    assign is_csr   = inst.csr.op == backend_pkg::OP_CSR;

    assign ready_go    = !is_load || rd_done;
    assign mem_allowin = !mem_valid || ready_go;

    assign ram_we    = mem_valid && is_store && !flush;
    assign ram_en    = ram_we || (mem_valid && is_load && !rd_done && !flush);
    assign ram_addr  = mem_result[backend_pkg::RAM_AW+1:2]; // Word address.
    assign ram_wdata = mem_rkd;

    assign mem_wb_valid      = mem_valid && ready_go && !flush;
    assign mem_wb_pc         = mem_pc;
    assign mem_wb_inst       = mem_inst;
    assign mem_wb_result     = is_load ? ram_rdata : mem_result;
    assign mem_wb_dest       = inst.r2i12.rd;
    assign mem_wb_syscall    = mem_inst[31:15] == backend_pkg::INST_SYSCALL_HI;
    assign mem_wb_ertn       = mem_inst == backend_pkg::INST_ERTN;
    assign mem_wb_gr_we      = !is_store && !mem_wb_syscall && !mem_wb_ertn;
    assign mem_wb_csr_re     = is_csr;
    assign mem_wb_csr_we     = is_csr && inst.csr.rj != 5'd0; // csrrd has rj of 0.
    assign mem_wb_csr_num    = inst.csr.csr_num;
    assign mem_wb_csr_wvalue = mem_rkd;
    assign mem_wb_csr_wmask  = (inst.csr.rj == 5'd1) ? '1 : mem_rj_value;

    // A stalled stage keeps its entry while the offer waits.
    a_hold_entry: assert property (@(posedge clk) disable iff (!resetn)
        (ex_valid && !mem_allowin) |=> ($stable(mem_pc) && $stable(mem_inst)));

    // Stores behind a syscall or ertn must not reach the RAM.
    a_no_store_on_flush: assert property (@(posedge clk) disable iff (!resetn)
        !(ram_we && flush));

endmodule

//--- wb/csr_file.sv
module csr_file (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic [13:0]                  csr_num,
    input  logic                         csr_re,
    input  logic                         csr_we,
    input  logic [backend_pkg::XLEN-1:0] csr_wvalue,
    input  logic [backend_pkg::XLEN-1:0] csr_wmask,
    input  logic                         wb_ex,
    input  logic                         wb_ertn,
    input  logic [backend_pkg::XLEN-1:0] wb_csr_pc,
    input  logic [5:0]                   wb_ecode,
    output logic [backend_pkg::XLEN-1:0] csr_rvalue,
    output logic [backend_pkg::XLEN-1:0] ex_entry,
    output logic [backend_pkg::XLEN-1:0] era
);

    logic [1:0]                   crmd_plv;
    logic                         crmd_ie;
    logic [1:0]                   prmd_pplv;
    logic                         prmd_pie;
    logic [5:0]                   estat_ecode;
    logic [25:0]                  eentry_va;
    logic [backend_pkg::XLEN-1:0] save [4];
    logic [backend_pkg::XLEN-1:0] csr_old;
    logic [backend_pkg::XLEN-1:0] csr_new;

    always_comb begin
        case (csr_num)
            backend_pkg::CSR_CRMD:   csr_old = {29'd0, crmd_ie, crmd_plv};
            backend_pkg::CSR_PRMD:   csr_old = {29'd0, prmd_pie, prmd_pplv};
            backend_pkg::CSR_ESTAT:  csr_old = {10'd0, estat_ecode, 16'd0};
            backend_pkg::CSR_ERA:    csr_old = era;
            backend_pkg::CSR_EENTRY: csr_old = {eentry_va, 6'd0};
            backend_pkg::CSR_SAVE0:  csr_old = save[0];
            backend_pkg::CSR_SAVE1:  csr_old = save[1];
            backend_pkg::CSR_SAVE2:  csr_old = save[2];
            backend_pkg::CSR_SAVE3:  csr_old = save[3];
            default:                 csr_old = '0; // Unimplemented.
        endcase
    end

    assign csr_new    = (csr_wvalue & csr_wmask) | (csr_old & ~csr_wmask);
    assign csr_rvalue = csr_re ? csr_old : '0;
    assign ex_entry   = {eentry_va, 6'd0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv    <= 2'd0;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= 2'd0;
            prmd_pie    <= 1'b0;
            estat_ecode <= 6'd0;
            era         <= '0;
            eentry_va   <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (wb_ex) begin
            prmd_pplv   <= crmd_plv;
            prmd_pie    <= crmd_ie;
            crmd_plv    <= 2'd0; // Enter kernel with interrupts off.
            crmd_ie     <= 1'b0;
            era         <= wb_csr_pc;
            estat_ecode <= wb_ecode;
        end else if (wb_ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we) begin
            case (csr_num)
                backend_pkg::CSR_CRMD:   {crmd_ie, crmd_plv} <= csr_new[2:0];
                backend_pkg::CSR_PRMD:   {prmd_pie, prmd_pplv} <= csr_new[2:0];
                backend_pkg::CSR_ESTAT:  estat_ecode <= csr_new[21:16];
                backend_pkg::CSR_ERA:    era <= csr_new;
                backend_pkg::CSR_EENTRY: eentry_va <= csr_new[31:6];
                backend_pkg::CSR_SAVE0:  save[0] <= csr_new;
                backend_pkg::CSR_SAVE1:  save[1] <= csr_new;
                backend_pkg::CSR_SAVE2:  save[2] <= csr_new;
                backend_pkg::CSR_SAVE3:  save[3] <= csr_new;
                default: ;
            endcase
        end
    end

    // Write-back must squash the CSR write of the faulting instruction.
    a_no_write_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        !(csr_we && wb_ex));

endmodule

//--- wb/wb_stage.sv
module wb_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         mem_wb_valid,
    input  logic [backend_pkg::XLEN-1:0] mem_wb_pc,
    input  logic [31:0]                  mem_wb_inst,
    input  logic [backend_pkg::XLEN-1:0] mem_wb_result,
    input  logic [4:0]                   mem_wb_dest,
    input  logic                         mem_wb_gr_we,
    input  logic                         mem_wb_csr_re,
    input  logic                         mem_wb_csr_we,
    input  logic [13:0]                  mem_wb_csr_num,
    input  logic [backend_pkg::XLEN-1:0] mem_wb_csr_wmask,
    input  logic [backend_pkg::XLEN-1:0] mem_wb_csr_wvalue,
    input  logic                         mem_wb_syscall,
    input  logic                         mem_wb_ertn,
    input  logic [backend_pkg::XLEN-1:0] csr_rvalue,
    input  logic [backend_pkg::XLEN-1:0] ex_entry,
    input  logic [backend_pkg::XLEN-1:0] era,
    output logic [13:0]                  csr_num,
    output logic                         csr_re,
    output logic                         csr_we,
    output logic [backend_pkg::XLEN-1:0] csr_wvalue,
    output logic [backend_pkg::XLEN-1:0] csr_wmask,
    output logic                         wb_ex,
    output logic                         wb_ertn,
    output logic [backend_pkg::XLEN-1:0] wb_csr_pc,
    output logic [5:0]                   wb_ecode,
    output logic                         rf_we,
    output logic [4:0]                   rf_waddr,
    output logic [backend_pkg::XLEN-1:0] rf_wdata,
    output logic                         flush,
    output logic [backend_pkg::XLEN-1:0] flush_pc,
    output logic                         debug_wb_valid,
    output logic [backend_pkg::XLEN-1:0] debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_we,
    output logic [4:0]                   debug_wb_rf_wnum,
    output logic [backend_pkg::XLEN-1:0] debug_wb_rf_wdata
);

    logic                         wb_valid;
    logic [backend_pkg::XLEN-1:0] wb_pc;
    logic [backend_pkg::XLEN-1:0] wb_result;
    logic [4:0]                   wb_dest;
    logic                         wb_gr_we;
    logic                         wb_csr_re;
    logic                         wb_csr_we;
    logic [13:0]                  wb_csr_num;
    logic [backend_pkg::XLEN-1:0] wb_csr_wmask;
    logic [backend_pkg::XLEN-1:0] wb_csr_wvalue;
    logic                         wb_syscall;
    logic                         wb_is_ertn;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_wb_valid; // Always ready.
        end
    end

    always_ff @(posedge clk) begin
        wb_pc         <= mem_wb_pc;
        wb_result     <= mem_wb_result;
        wb_dest       <= mem_wb_dest;
        wb_gr_we      <= mem_wb_gr_we;
        wb_csr_re     <= mem_wb_csr_re;
        wb_csr_we     <= mem_wb_csr_we;
        wb_csr_num    <= mem_wb_csr_num;
        wb_csr_wmask  <= mem_wb_csr_wmask;
        wb_csr_wvalue <= mem_wb_csr_wvalue;
        wb_syscall    <= mem_wb_syscall;
        wb_is_ertn    <= mem_wb_ertn;
    end

    assign wb_ex     = wb_valid && wb_syscall;
    assign wb_ertn   = wb_valid && wb_is_ertn;
    assign wb_ecode  = wb_syscall ? backend_pkg::ECODE_SYS : 6'd0;
    assign wb_csr_pc = wb_pc;

    assign csr_num    = wb_csr_num;
    assign csr_re     = wb_valid && wb_csr_re;
    assign csr_we     = wb_valid && wb_csr_we && !wb_ex;
    assign csr_wvalue = wb_csr_wvalue;
    assign csr_wmask  = wb_csr_wmask;

    assign rf_we    = wb_valid && wb_gr_we && !wb_ex;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_csr_re ? csr_rvalue : wb_result; // CSR ops return the old value.

    assign flush    = wb_ex || wb_ertn;
    assign flush_pc = wb_ex ? ex_entry : era;

    assign debug_wb_valid    = wb_valid;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = rf_wdata;

    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(wb_ex && wb_ertn));

endmodule

//--- rtl/backend_top.sv
module backend_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         ex_valid,
    input  logic [backend_pkg::XLEN-1:0] ex_pc,
    input  logic [31:0]                  ex_inst,
    input  logic [backend_pkg::XLEN-1:0] ex_result,
    input  logic [backend_pkg::XLEN-1:0] ex_rkd,
    input  logic [backend_pkg::XLEN-1:0] ex_rj_value,
    output logic                         mem_allowin,
    output logic                         flush,
    output logic [backend_pkg::XLEN-1:0] flush_pc,
    input  logic [4:0]                   rf_raddr,
    output logic [backend_pkg::XLEN-1:0] rf_rdata,
    output logic                         debug_wb_valid,
    output logic [backend_pkg::XLEN-1:0] debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_we,
    output logic [4:0]                   debug_wb_rf_wnum,
    output logic [backend_pkg::XLEN-1:0] debug_wb_rf_wdata
);

    logic                           ram_en;
    logic                           ram_we;
    logic [backend_pkg::RAM_AW-1:0] ram_addr;
    logic [backend_pkg::XLEN-1:0]   ram_wdata;
    logic [backend_pkg::XLEN-1:0]   ram_rdata;
    logic                           mem_wb_valid;
    logic [backend_pkg::XLEN-1:0]   mem_wb_pc;
    logic [31:0]                    mem_wb_inst;
    logic [backend_pkg::XLEN-1:0]   mem_wb_result;
    logic [4:0]                     mem_wb_dest;
    logic                           mem_wb_gr_we;
    logic                           mem_wb_csr_re;
    logic                           mem_wb_csr_we;
    logic [13:0]                    mem_wb_csr_num;
    logic [backend_pkg::XLEN-1:0]   mem_wb_csr_wmask;
    logic [backend_pkg::XLEN-1:0]   mem_wb_csr_wvalue;
    logic                           mem_wb_syscall;
    logic                           mem_wb_ertn;
    logic [13:0]                    csr_num;
    logic                           csr_re;
    logic                           csr_we;
    logic [backend_pkg::XLEN-1:0]   csr_wvalue;
    logic [backend_pkg::XLEN-1:0]   csr_wmask;
    logic [backend_pkg::XLEN-1:0]   csr_rvalue;
    logic                           wb_ex;
    logic                           wb_ertn;
    logic [backend_pkg::XLEN-1:0]   wb_csr_pc;
    logic [5:0]                     wb_ecode;
    logic [backend_pkg::XLEN-1:0]   ex_entry;
    logic [backend_pkg::XLEN-1:0]   era;
    logic                           rf_we;
    logic [4:0]                     rf_waddr;
    logic [backend_pkg::XLEN-1:0]   rf_wdata;

    mem_stage u_mem_stage (.*);

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage u_wb_stage (.*);

    csr_file u_csr_file (.*);

    reg_file u_reg_file (
        .clk   (clk),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

//--- test/backend_tb.sv
module backend_tb;

    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 100;

    logic        clk;
    logic        resetn;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_result;
    logic [31:0] ex_rkd;
    logic [31:0] ex_rj_value;
    logic [4:0]  rf_raddr;
    logic        mem_allowin;
    logic        flush;
    logic [31:0] flush_pc;
    logic [31:0] rf_rdata;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // One entry per offered instruction, with its expected trace.
    logic [31:0] row_pc [MAX_ROWS];
    logic [31:0] row_inst [MAX_ROWS];
    logic [31:0] row_result [MAX_ROWS];
    logic [31:0] row_rkd [MAX_ROWS];
    logic [31:0] row_rjv [MAX_ROWS];
    logic        row_discard [MAX_ROWS];
    logic [3:0]  exp_we [MAX_ROWS];
    logic [4:0]  exp_wnum [MAX_ROWS];
    logic [31:0] exp_wdata [MAX_ROWS];
    logic        exp_flush [MAX_ROWS];
    logic [31:0] exp_flush_pc [MAX_ROWS];
    int          n_rows;
    int          n_expected;
    int          n_commits;

    // Architectural state as the table is built.
    logic [31:0] gpr_model [32];
    logic        gpr_written [32];
    logic [31:0] ram_model [256];
    logic [31:0] csr_model [16384];
    logic [31:0] lfsr_state;
    logic [31:0] next_pc;

    backend_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        int          i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // Bits that each implemented CSR keeps.
    function automatic logic [31:0] csr_field(input logic [13:0] num);
        case (num)
            backend_pkg::CSR_CRMD, backend_pkg::CSR_PRMD: return 32'h0000_0007;
            backend_pkg::CSR_ESTAT:  return 32'h003f_0000;
            backend_pkg::CSR_EENTRY: return 32'hffff_ffc0;
            backend_pkg::CSR_ERA, backend_pkg::CSR_SAVE0, backend_pkg::CSR_SAVE1,
            backend_pkg::CSR_SAVE2, backend_pkg::CSR_SAVE3: return 32'hffff_ffff;
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic push_row(input logic [31:0] inst, result, rkd, rjv, input logic disc,
                            input logic [3:0] we, input logic [4:0] wnum,
                            input logic [31:0] wdata, input logic fl,
                            input logic [31:0] fl_pc);
        row_pc[n_rows]       = next_pc;
        row_inst[n_rows]     = inst;
        row_result[n_rows]   = result;
        row_rkd[n_rows]      = rkd;
        row_rjv[n_rows]      = rjv;
        row_discard[n_rows]  = disc;
        exp_we[n_rows]       = we;
        exp_wnum[n_rows]     = wnum;
        exp_wdata[n_rows]    = wdata;
        exp_flush[n_rows]    = fl;
        exp_flush_pc[n_rows] = fl_pc;
        if (!disc) begin
            n_expected++;
        end
        n_rows++;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic write_gpr(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 5'd0) begin
            gpr_model[rd]   = val;
            gpr_written[rd] = 1'b1;
        end
    endtask

    task automatic alu_row(input logic [4:0] rd, input logic disc);
        logic [31:0] val;
        val = rand_word();
        push_row({17'h00020, 5'd3, 5'd2, rd}, val, 32'h0, 32'h0, disc, 4'hf, rd, val,
                 1'b0, 32'h0);
        if (!disc) begin
            write_gpr(rd, val);
        end
    endtask

    task automatic store_row(input logic [31:0] addr, input logic disc);
        logic [31:0] data;
        data = rand_word();
        push_row({backend_pkg::OP_ST_W, 12'd0, 5'd1, 5'd4}, addr, data, 32'h0, disc,
                 4'h0, 5'd0, 32'h0, 1'b0, 32'h0);
        if (!disc) begin
            ram_model[addr[9:2]] = data;
        end
    endtask

    task automatic load_row(input logic [4:0] rd, input logic [31:0] addr);
        push_row({backend_pkg::OP_LD_W, 12'd0, 5'd1, rd}, addr, 32'h0, 32'h0, 1'b0,
                 4'hf, rd, ram_model[addr[9:2]], 1'b0, 32'h0);
        write_gpr(rd, ram_model[addr[9:2]]);
    endtask

    // rj of 0 reads, 1 writes all bits, anything else writes under the mask.
    task automatic csr_row(input logic [4:0] rj, input logic [13:0] num, input logic [4:0] rd,
                           input logic [31:0] value, input logic [31:0] mask);
        logic [31:0] old;
        logic [31:0] m;
        old = csr_model[num];
        m   = (rj == 5'd0) ? 32'h0 : (rj == 5'd1) ? 32'hffff_ffff : mask;
        m   = m & csr_field(num);
        push_row({backend_pkg::OP_CSR, num, rj, rd}, 32'h0, value, mask, 1'b0, 4'hf, rd, old,
                 1'b0, 32'h0);
        csr_model[num] = (old & ~m) | (value & m);
        write_gpr(rd, old);
    endtask

    task automatic syscall_row();
        csr_model[backend_pkg::CSR_ERA]   = next_pc;
        csr_model[backend_pkg::CSR_ESTAT] = {10'd0, backend_pkg::ECODE_SYS, 16'd0};
        push_row({backend_pkg::INST_SYSCALL_HI, 15'd0}, 32'h0, 32'h0, 32'h0, 1'b0, 4'h0,
                 5'd0, 32'h0, 1'b1, csr_model[backend_pkg::CSR_EENTRY]);
        csr_model[backend_pkg::CSR_PRMD] = csr_model[backend_pkg::CSR_CRMD] & 32'h7;
        csr_model[backend_pkg::CSR_CRMD] = csr_model[backend_pkg::CSR_CRMD] & ~32'h7;
    endtask

    task automatic ertn_row();
        push_row(backend_pkg::INST_ERTN, 32'h0, 32'h0, 32'h0, 1'b0, 4'h0, 5'd0, 32'h0,
                 1'b1, csr_model[backend_pkg::CSR_ERA]);
        csr_model[backend_pkg::CSR_CRMD] = csr_model[backend_pkg::CSR_PRMD] & 32'h7;
    endtask

    task automatic fill_table();
        int i;
        for (i = 0; i < 16384; i++) begin
            csr_model[i] = 32'h0;
        end
        for (i = 0; i < 32; i++) begin
            gpr_model[i]   = 32'h0;
            gpr_written[i] = 1'b0;
        end
        alu_row(5'd1, 1'b0);
        alu_row(5'd2, 1'b0);
        alu_row(5'd0, 1'b0);
        alu_row(5'd2, 1'b0);
        alu_row(5'd5, 1'b0);
        store_row(32'h0000_0040, 1'b0);
        store_row(32'h0000_0044, 1'b0);
        load_row(5'd6, 32'h0000_0040);
        load_row(5'd7, 32'h0000_0044);
        alu_row(5'd8, 1'b0);
        csr_row(5'd1, backend_pkg::CSR_SAVE0, 5'd10, rand_word(), rand_word());
        csr_row(5'd0, backend_pkg::CSR_SAVE0, 5'd11, 32'h0, 32'h0);
        csr_row(5'd2, backend_pkg::CSR_SAVE0, 5'd12, rand_word(), rand_word());
        csr_row(5'd0, backend_pkg::CSR_SAVE0, 5'd13, 32'h0, 32'h0);
        csr_row(5'd1, backend_pkg::CSR_EENTRY, 5'd14, 32'h1c00_8000, 32'h0);
        syscall_row();
        store_row(32'h0000_0040, 1'b1); // Dropped in the mem stage.
        alu_row(5'd15, 1'b1);           // Offered during the flush.
        csr_row(5'd0, backend_pkg::CSR_ERA, 5'd16, 32'h0, 32'h0);
        csr_row(5'd0, backend_pkg::CSR_ESTAT, 5'd17, 32'h0, 32'h0);
        csr_row(5'd1, backend_pkg::CSR_PRMD, 5'd18, 32'h0000_0007, 32'h0);
        ertn_row();
        alu_row(5'd19, 1'b1);
        alu_row(5'd20, 1'b1);
        csr_row(5'd0, backend_pkg::CSR_CRMD, 5'd21, 32'h0, 32'h0);
        load_row(5'd23, 32'h0000_0040);
        alu_row(5'd24, 1'b0);
    endtask

    initial begin : trace_monitor
        int idx;
        idx = 0;
        n_commits = 0;
        forever begin
            @(negedge clk);
            if (resetn && debug_wb_valid) begin
                while (idx < n_rows && row_discard[idx]) begin
                    idx++;
                end
                if (idx >= n_rows) begin
                    abort_run("A commit appeared after the last expected instruction.");
                end
                check_value("debug_wb_pc", debug_wb_pc, row_pc[idx]);
                check_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'(exp_we[idx]));
                if (exp_we[idx] != 4'h0) begin
                    check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_wnum[idx]));
                    check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata[idx]);
                end
                check_value("flush", 32'(flush), 32'(exp_flush[idx]));
                if (exp_flush[idx]) begin
                    check_value("flush_pc", flush_pc, exp_flush_pc[idx]);
                end
                idx++;
                n_commits++;
            end else if (resetn) begin
                check_value("flush", 32'(flush), 32'h0);
            end
        end
    end

    initial begin
        int   i;
        int   waited;
        logic prev_load;
        resetn      = 1'b0;
        ex_valid    = 1'b0;
        ex_pc       = 32'h0;
        ex_inst     = 32'h0;
        ex_result   = 32'h0;
        ex_rkd      = 32'h0;
        ex_rj_value = 32'h0;
        rf_raddr    = 5'd0;
        lfsr_state  = 32'h78a2_35fe;
        next_pc     = 32'h1c00_0000;
        n_rows      = 0;
        n_expected  = 0;
        fill_table();
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("mem_allowin", 32'(mem_allowin), 32'h1);
        check_value("debug_wb_valid", 32'(debug_wb_valid), 32'h0);
        @(posedge clk);
        prev_load = 1'b0;
        for (i = 0; i < n_rows; i++) begin
            ex_valid    <= 1'b1;
            ex_pc       <= row_pc[i];
            ex_inst     <= row_inst[i];
            ex_result   <= row_result[i];
            ex_rkd      <= row_rkd[i];
            ex_rj_value <= row_rjv[i];
            waited = 0;
            @(negedge clk);
            if (prev_load) begin
                check_value("mem_allowin", 32'(mem_allowin), 32'h0); // Load read cycle.
            end
            while (!mem_allowin) begin
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run("Timed out waiting for mem_allowin.");
                end
                @(negedge clk);
            end
            @(posedge clk);
            prev_load = row_inst[i][31:22] == backend_pkg::OP_LD_W;
        end
        ex_valid <= 1'b0;
        waited = 0;
        while (n_commits < n_expected) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timed out waiting for the remaining commits.");
            end
            @(negedge clk);
        end
        for (i = 0; i < 32; i++) begin
            if (i == 0 || gpr_written[i]) begin
                @(posedge clk);
                rf_raddr <= i[4:0];
                @(negedge clk);
                check_value($sformatf("rf_rdata r%0d", i), rf_rdata, gpr_model[i]);
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- filelist.f
common/backend_pkg.sv
rtl/reg_file.sv
mem/data_ram.sv
mem/mem_stage.sv
wb/csr_file.sv
wb/wb_stage.sv
rtl/backend_top.sv
test/backend_tb.sv

//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert
TOP       = backend_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
